// File: Makefile
# Verilator build and run of the cache testbench

TOP      ?= cache_tb
FILELIST ?= filelist.f
OBJ_DIR  ?= obj_dir
SEED     ?= 32'hcce9466a
VFLAGS   ?= --binary --timing --assert -Wno-fatal
PASS_MSG  = Test passed

.PHONY: all compile run clean

all: run

compile:
	verilator $(VFLAGS) --top-module $(TOP) -GSEED="$(SEED)" -f $(FILELIST) -Mdir $(OBJ_DIR)

# pass only when the pass line appears in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: filelist.f
+incdir+source
+incdir+testbench
source/cache_pkg.sv
source/mem_pkg.sv
source/cache_array.sv
source/block_mover.sv
source/cache_controller.sv
source/cache_top.sv
testbench/cache_tb.sv

// File: source/block_mover.sv
//////////////////////////////
// block mover
// byte-serial drain of a victim block or fill of a new block
// over the req/ack memory port, lowest address first
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module block_mover import cache_pkg::*, mem_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  move_op_e              op,
    input  cache_addr_u           base,
    input  block_t                drain_block,
    output logic                  done,
    output block_t                fill_block,
    output logic                  mem_req,
    output logic                  mem_we,
    output logic [`ADDR_BITS-1:0] mem_addr,
    output mem_byte_t             mem_wdata,
    input  logic                  mem_ack,
    input  mem_byte_t             mem_rdata
);

    localparam int CNT_BITS = $clog2(`BLOCK_BYTES);
    localparam int BYTE_W   = $bits(mem_byte_t);

    logic                busy;
    logic [CNT_BITS-1:0] cnt;      // byte within the block
    move_op_e            op_q;
    cache_addr_u         base_q;
    logic                last_byte;
    logic                byte_done;

    assign last_byte = (cnt == CNT_BITS'(`BLOCK_BYTES - 1));
    assign byte_done = busy && mem_req && mem_ack;

    // block base plus byte counter
    assign mem_addr  = {base_q.f.tag, base_q.f.index, cnt};
    assign mem_we    = mem_req && (op_q == MOVE_DRAIN);
    assign mem_wdata = drain_block[cnt * BYTE_W +: BYTE_W];

    //////////////////////////////
    // handshake sequencing
    //////////////////////////////
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            busy    <= 1'b0;
            cnt     <= '0;
            op_q    <= MOVE_FILL;
            mem_req <= 1'b0;
            done    <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (start && !busy)
            begin
                busy <= 1'b1;
                cnt  <= '0;
                op_q <= op;
            end
            else if (byte_done)
            begin
                mem_req <= 1'b0;                   // one idle cycle between bytes
                cnt     <= cnt + 1'b1;
                if (last_byte)
                begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
            else if (busy && !mem_req)
                mem_req <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (start && !busy)
            base_q <= base;
        if (byte_done && op_q == MOVE_FILL)
            fill_block[cnt * BYTE_W +: BYTE_W] <= mem_rdata;
    end

endmodule

`default_nettype wire

// File: source/cache_array.sv
//////////////////////////////
// cache array
// tag, valid, dirty, data and LRU age storage for every set and way
// lookup and victim choice are combinational on the current index
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cache_array import cache_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  cache_addr_u            lk_addr,
    input  logic                   wr_word,
    input  logic [`WORD_BITS-1:0]  wr_data,
    input  logic                   install,
    input  block_t                 install_block,
    output logic                   hit,
    output way_t                   hit_way,
    output logic [`WORD_BITS-1:0]  rd_word,
    output way_t                   victim_way,
    output logic                   victim_valid,
    output logic                   victim_dirty,
    output logic [`TAG_BITS-1:0]   victim_tag,
    output block_t                 victim_block
);

    localparam int SETS = 1 << `INDEX_BITS;

    logic [`BLOCK_WORDS-1:0][`WORD_BITS-1:0] data_mem [SETS][`NUM_WAYS];
    logic [`TAG_BITS-1:0]                    tag_mem  [SETS][`NUM_WAYS];
    logic [`NUM_WAYS-1:0]                    valid_bits [SETS];
    logic [`NUM_WAYS-1:0]                    dirty_bits [SETS];
    age_t                                    age_mem  [SETS][`NUM_WAYS];

    logic [`INDEX_BITS-1:0] idx;
    logic                   touch;
    way_t                   use_way;

    assign idx = lk_addr.f.index;

    //////////////////////////////
    // lookup
    //////////////////////////////
    always_comb
    begin
        hit = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `NUM_WAYS; w++)
        begin
            if (valid_bits[idx][w] && tag_mem[idx][w] == lk_addr.f.tag)
            begin
                hit = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    assign rd_word = data_mem[idx][hit_way][lk_addr.f.offset];

    // lowest invalid way first, otherwise the oldest one
    always_comb
    begin
        victim_way = '0;
        for (int w = `NUM_WAYS - 1; w >= 0; w--)
        begin
            if (age_mem[idx][w] == age_t'(`NUM_WAYS - 1))
                victim_way = way_t'(w);
        end
        for (int w = `NUM_WAYS - 1; w >= 0; w--)
        begin
            if (!valid_bits[idx][w])
                victim_way = way_t'(w);
        end
    end

    assign victim_valid = valid_bits[idx][victim_way];
    assign victim_dirty = dirty_bits[idx][victim_way];
    assign victim_tag   = tag_mem[idx][victim_way];
    assign victim_block = data_mem[idx][victim_way];

    //////////////////////////////
    // update
    //////////////////////////////
    // a hit with no write is a read; repeating it on the newest way changes nothing
    assign touch   = install || hit;
    assign use_way = install ? victim_way : hit_way;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int s = 0; s < SETS; s++)
            begin
                valid_bits[s] <= '0;
                dirty_bits[s] <= '0;
                for (int w = 0; w < `NUM_WAYS; w++)
                    age_mem[s][w] <= age_t'(w);    // ages start as a permutation
            end
        end
        else if (touch)
        begin
            for (int w = 0; w < `NUM_WAYS; w++)
            begin
                if (way_t'(w) == use_way)
                    age_mem[idx][w] <= '0;
                else if (age_mem[idx][w] < age_mem[idx][use_way])
                    age_mem[idx][w] <= age_mem[idx][w] + 1'b1;
            end
            if (install)
            begin
                valid_bits[idx][victim_way] <= 1'b1;
                dirty_bits[idx][victim_way] <= 1'b0;   // refilled block is clean
            end
            else if (wr_word)
                dirty_bits[idx][hit_way] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (install)
        begin
            data_mem[idx][victim_way] <= install_block;
            tag_mem[idx][victim_way]  <= lk_addr.f.tag;
        end
        else if (wr_word && hit)
            data_mem[idx][hit_way][lk_addr.f.offset] <= wr_data;
    end

endmodule

`default_nettype wire

// File: source/cache_controller.sv
//////////////////////////////
// cache controller
// request FSM: lookup, optional write-back of the victim,
// refill, install and the response to the cpu
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cache_controller import cache_pkg::*, mem_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    // cpu
    input  logic                  cpu_req_valid,
    input  cache_addr_u           cpu_addr,
    input  logic                  cpu_write,
    input  logic [`WORD_BITS-1:0] cpu_wdata,
    output logic                  cpu_ready,
    output logic                  cpu_resp_valid,
    output logic [`WORD_BITS-1:0] cpu_rdata,
    // array
    output cache_addr_u           lk_addr,
    output logic                  wr_word,
    output logic [`WORD_BITS-1:0] wr_data,
    output logic                  install,
    output block_t                install_block,
    input  logic                  hit,
    input  way_t                  hit_way,
    input  logic [`WORD_BITS-1:0] rd_word,
    input  way_t                  victim_way,
    input  logic                  victim_valid,
    input  logic                  victim_dirty,
    input  logic [`TAG_BITS-1:0]  victim_tag,
    input  block_t                victim_block,
    // block mover
    output logic                  mv_start,
    output move_op_e              mv_op,
    output cache_addr_u           mv_base,
    output block_t                mv_block,
    input  logic                  mv_done,
    input  block_t                fill_block
);

    localparam logic [2:0] ST_IDLE    = 3'd0;
    localparam logic [2:0] ST_COMPARE = 3'd1;
    localparam logic [2:0] ST_DRAIN   = 3'd2;
    localparam logic [2:0] ST_FILL    = 3'd3;
    localparam logic [2:0] ST_INSTALL = 3'd4;

    logic [2:0]            state;
    cache_addr_u           addr_q;
    logic                  write_q;
    logic [`WORD_BITS-1:0] wdata_q;
    way_t                  fill_way;   // way freed for this miss
    logic                  refilled;
    logic                  resolved;
    logic                  need_drain;
    cache_addr_u           drain_base;
    cache_addr_u           fill_base;

    // after a refill the line must sit in the way that was freed
    assign resolved   = hit && (!refilled || hit_way == fill_way);
    assign need_drain = victim_valid && victim_dirty;
    assign drain_base = {victim_tag, addr_q.f.index, {(`OFFSET_BITS + 1){1'b0}}};
    assign fill_base  = {addr_q.f.tag, addr_q.f.index, {(`OFFSET_BITS + 1){1'b0}}};

    assign cpu_ready     = (state == ST_IDLE);
    assign lk_addr       = addr_q;
    assign wr_word       = (state == ST_COMPARE) && resolved && write_q;
    assign wr_data       = wdata_q;
    assign install       = (state == ST_INSTALL);
    assign install_block = fill_block;

    //////////////////////////////
    // state machine
    //////////////////////////////
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state          <= ST_IDLE;
            addr_q         <= '0;
            write_q        <= 1'b0;
            refilled       <= 1'b0;
            cpu_resp_valid <= 1'b0;
            mv_start       <= 1'b0;
            mv_op          <= MOVE_FILL;
        end
        else
        begin
            cpu_resp_valid <= 1'b0;
            mv_start       <= 1'b0;
            case (state)
                ST_IDLE:
                    if (cpu_req_valid)
                    begin
                        addr_q   <= cpu_addr;
                        write_q  <= cpu_write;
                        refilled <= 1'b0;
                        state    <= ST_COMPARE;
                    end
                ST_COMPARE:
                    if (resolved)
                    begin
                        cpu_resp_valid <= 1'b1;
                        state          <= ST_IDLE;
                    end
                    else
                    begin
                        mv_start <= 1'b1;
                        mv_op    <= need_drain ? MOVE_DRAIN : MOVE_FILL;
                        state    <= need_drain ? ST_DRAIN : ST_FILL;
                    end
                ST_DRAIN:
                    if (mv_done)
                    begin
                        mv_start <= 1'b1;    // mover is idle again
                        mv_op    <= MOVE_FILL;
                        state    <= ST_FILL;
                    end
                ST_FILL:
                    if (mv_done)
                        state <= ST_INSTALL;
                ST_INSTALL:
                begin
                    refilled <= 1'b1;
                    state    <= ST_COMPARE;   // second compare hits
                end
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == ST_IDLE && cpu_req_valid)
            wdata_q <= cpu_wdata;
        if (state == ST_COMPARE && resolved && !write_q)
            cpu_rdata <= rd_word;
        if (state == ST_COMPARE && !resolved)
        begin
            fill_way <= victim_way;
            mv_block <= victim_block;   // held victim for the drain
            mv_base  <= need_drain ? drain_base : fill_base;
        end
        if (state == ST_DRAIN && mv_done)
            mv_base <= fill_base;
    end

endmodule

`default_nettype wire

// File: source/cache_macros.svh
//////////////////////////////
// cache geometry
// address split, block size and associativity shared by the
// controller, the tag/data array and the block mover
//////////////////////////////
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// cpu side
`define ADDR_BITS    16
`define WORD_BITS    16

// block layout
`define BLOCK_WORDS  8
`define OFFSET_BITS  3
`define BLOCK_BITS   128
`define BLOCK_BYTES  16

// set and way selection
`define INDEX_BITS   8
`define TAG_BITS     4
`define NUM_WAYS     4
`define WAY_BITS     2

`endif

// File: source/cache_pkg.sv
//////////////////////////////
// cache types
// address decode, block and way/age types
//////////////////////////////
`default_nettype none

`include "cache_macros.svh"

package cache_pkg;

    // one byte address, split into fields inside the cache, used flat toward memory
    typedef union packed {
        struct packed {
            logic [`TAG_BITS-1:0]    tag;
            logic [`INDEX_BITS-1:0]  index;
            logic [`OFFSET_BITS-1:0] offset;   // word within the block
            logic                    byte_sel; // always 0 for word requests
        } f;
        logic [`ADDR_BITS-1:0] flat;
    } cache_addr_u;

    typedef logic [`BLOCK_BITS-1:0] block_t;   // word 0 in the low bits
    typedef logic [`WAY_BITS-1:0]   way_t;
    typedef logic [`WAY_BITS-1:0]   age_t;     // 0 is most recent

endpackage

`default_nettype wire

// File: source/cache_top.sv
//////////////////////////////
// cache top
// 4-way write-back data cache with a byte-wide memory port
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cache_top import cache_pkg::*, mem_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cpu_req_valid,
    input  cache_addr_u           cpu_addr,
    input  logic                  cpu_write,
    input  logic [`WORD_BITS-1:0] cpu_wdata,
    output logic                  cpu_ready,
    output logic                  cpu_resp_valid,
    output logic [`WORD_BITS-1:0] cpu_rdata,
    output logic                  mem_req,
    output logic                  mem_we,
    output logic [`ADDR_BITS-1:0] mem_addr,
    output mem_byte_t             mem_wdata,
    input  logic                  mem_ack,
    input  mem_byte_t             mem_rdata
);

    // controller <-> array
    cache_addr_u           lk_addr;
    logic                  wr_word;
    logic [`WORD_BITS-1:0] wr_data;
    logic                  install;
    block_t                install_block;
    logic                  hit;
    way_t                  hit_way;
    logic [`WORD_BITS-1:0] rd_word;
    way_t                  victim_way;
    logic                  victim_valid;
    logic                  victim_dirty;
    logic [`TAG_BITS-1:0]  victim_tag;
    block_t                victim_block;

    // controller <-> mover
    logic                  mv_start;
    move_op_e              mv_op;
    cache_addr_u           mv_base;
    block_t                mv_block;
    logic                  mv_done;
    block_t                fill_block;

    cache_controller u_ctrl (.*);

    cache_array u_array (.*);

    block_mover u_mover
    (
        .clk         (clk),
        .reset       (reset),
        .start       (mv_start),
        .op          (mv_op),
        .base        (mv_base),
        .drain_block (mv_block),
        .done        (mv_done),
        .fill_block  (fill_block),
        .mem_req     (mem_req),
        .mem_we      (mem_we),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_ack     (mem_ack),
        .mem_rdata   (mem_rdata)
    );

endmodule

`default_nettype wire

// File: source/mem_pkg.sv
//////////////////////////////
// memory transfer types
// byte lane and block mover operation
//////////////////////////////
`default_nettype none

package mem_pkg;

    typedef logic [7:0] mem_byte_t;

    // fill reads a block in, drain writes the held victim out
    typedef enum logic {
        MOVE_FILL  = 1'b0,
        MOVE_DRAIN = 1'b1
    } move_op_e;

endpackage

`default_nettype wire

// File: testbench/cache_model.svh
//////////////////////////////
// cache reference model
// flat word memory over the initial memory pattern
//////////////////////////////
`ifndef CACHE_MODEL_SVH
`define CACHE_MODEL_SVH

logic [15:0] model_words   [0:32767];
bit          model_written [0:32767];
logic [15:0] written_addrs [$];          // each written word address once

// initial byte at a memory address, mixes in the high address byte
function automatic logic [7:0] init_byte(input logic [15:0] a);
    logic [31:0] v;
    v = {16'h0, a} * 32'd7 + 32'd3;
    return v[7:0] ^ a[15:8];
endfunction

// low byte sits at the even address
function automatic logic [15:0] init_word(input logic [15:0] a);
    return {init_byte({a[15:1], 1'b1}), init_byte({a[15:1], 1'b0})};
endfunction

function automatic logic [15:0] model_read(input logic [15:0] a);
    if (model_written[a[15:1]])
        return model_words[a[15:1]];
    return init_word(a);
endfunction

function automatic void model_write(input logic [15:0] a, input logic [15:0] d);
    if (!model_written[a[15:1]])
        written_addrs.push_back(a);
    model_written[a[15:1]] = 1'b1;
    model_words[a[15:1]]   = d;
endfunction

`endif

// File: testbench/cache_tb.sv
//////////////////////////////
// cache testbench
// cpu requests, a byte memory with random ack delay,
// every read checked against a flat word model
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cache_tb import cache_pkg::*, mem_pkg::*;
#(
    parameter logic [31:0] SEED = 32'hcce9_466a
);

    localparam int NUM_RANDOM = 400;
    // all cpu operations, rereads bounded by the number of writes
    localparam int NUM_OPS    = 1 + 2 + 10 + 28 + NUM_RANDOM + (NUM_RANDOM + 6);
    localparam int MAX_CYCLES = NUM_OPS * 80 + 16;

    logic                  clk;
    logic                  reset;
    logic                  cpu_req_valid;
    cache_addr_u           cpu_addr;
    logic                  cpu_write;
    logic [`WORD_BITS-1:0] cpu_wdata;
    logic                  cpu_ready;
    logic                  cpu_resp_valid;
    logic [`WORD_BITS-1:0] cpu_rdata;
    logic                  mem_req;
    logic                  mem_we;
    logic [`ADDR_BITS-1:0] mem_addr;
    mem_byte_t             mem_wdata;
    logic                  mem_ack;
    mem_byte_t             mem_rdata;

    mem_byte_t mem_bytes [0:65535];
    integer    stim_seed;
    integer    ack_seed;
    int        we_cycles;       // cycles with mem_we high
    int        errors;
    int        test_errors;
    int        tests_run;
    int        tests_failed;
    int        cycle_count;

    `include "cache_model.svh"

    cache_top UUT (.*);

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial
    begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run still busy after %0d cycles", MAX_CYCLES);
        $display("Test failed");
        $finish;
    end

    //////////////////////////////
    // memory responder
    //////////////////////////////
    initial
    begin
        int   wait_cnt;
        logic armed;
        mem_ack   = 1'b0;
        mem_rdata = '0;
        we_cycles = 0;
        ack_seed  = ~SEED;
        armed     = 1'b0;
        wait_cnt  = 0;
        for (int a = 0; a < 65536; a++)
            mem_bytes[a] = init_byte(16'(a));
        forever
        begin
            @(posedge clk);
            #5;
            mem_ack = 1'b0;
            if (mem_we)
                we_cycles++;
            if (mem_req)
            begin
                if (!armed)
                    wait_cnt = 1 + int'($unsigned($random(ack_seed)) % 4);   // 1 to 4 cycles
                armed = 1'b1;
                wait_cnt--;
                if (wait_cnt == 0)
                begin
                    armed   = 1'b0;
                    mem_ack = 1'b1;
                    if (mem_we)
                        mem_bytes[mem_addr] = mem_wdata;
                    else
                        mem_rdata = mem_bytes[mem_addr];
                end
            end
        end
    end

    // one request; latency counts to the edge that samples the response
    task automatic cpu_access(input logic wr, input logic [15:0] addr, input logic [15:0] wdata,
                              output logic [15:0] rdata, output int latency);
        while (!cpu_ready)
        begin
            @(posedge clk);
            #5;
        end
        cpu_req_valid = 1'b1;
        cpu_addr.flat = addr;
        cpu_write     = wr;
        cpu_wdata     = wdata;
        @(posedge clk);                 // accepting edge
        #5;
        cpu_req_valid = 1'b0;
        latency = 1;
        while (!cpu_resp_valid)
        begin
            @(posedge clk);
            #5;
            latency++;
        end
        rdata = cpu_rdata;
    endtask

    task automatic check_rdata(input logic [15:0] addr, input logic [15:0] got,
                               input logic [15:0] exp);
        assert (got === exp)
        else
        begin
            $display("FAILED t=%0t cpu_rdata (addr %h): got %h expected %h",
                     $time, addr, got, exp);
            test_errors++;
            errors++;
        end
    endtask

    task automatic report_mismatch(input string sig, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("FAILED t=%0t %s: got %0h expected %0h", $time, sig, got, exp);
        test_errors++;
        errors++;
    endtask

    task automatic note_error(input string msg);
        $display("t=%0t %s", $time, msg);
        test_errors++;
        errors++;
    endtask

    task automatic start_test();
        test_errors = 0;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_errors == 0)
            $display("test %s: ok", name);
        else
        begin
            tests_failed++;
            $display("test %s: %0d errors", name, test_errors);
        end
    endtask

    // mostly two crowded sets with six tags each, now and then anywhere
    function automatic logic [15:0] random_addr();
        logic [31:0] r;
        r = $random(stim_seed);
        if (r[1:0] != 2'b00)
            return {4'(r[31:8] % 6), (r[2] ? 8'h05 : 8'h9a), r[5:3], 1'b0};
        return {r[31:17], 1'b0};
    endfunction

    //////////////////////////////
    // stimulus
    //////////////////////////////
    initial
    begin
        logic [15:0] addr;
        logic [15:0] data;
        logic [15:0] got;
        logic [31:0] r;
        int          lat;
        int          we_before;
        int          in_mem;
        stim_seed     = SEED;
        errors        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        reset         = 1'b1;
        cpu_req_valid = 1'b0;
        cpu_addr      = '0;
        cpu_write     = 1'b0;
        cpu_wdata     = '0;
        repeat (16) @(posedge clk);
        #5;
        reset = 1'b0;

        start_test();
        assert (cpu_ready === 1'b1)
        else
            report_mismatch("cpu_ready", 32'(cpu_ready), 32'd1);
        assert (mem_req === 1'b0)
        else
            report_mismatch("mem_req", 32'(mem_req), 32'd0);
        cpu_access(1'b0, 16'h1234, '0, got, lat);
        check_rdata(16'h1234, got, model_read(16'h1234));
        end_test("cold read");

        start_test();
        cpu_access(1'b1, 16'h4566, 16'hbeef, got, lat);
        model_write(16'h4566, 16'hbeef);
        cpu_access(1'b0, 16'h4566, '0, got, lat);
        check_rdata(16'h4566, got, model_read(16'h4566));
        assert (lat == 2)
        else
            report_mismatch("cpu_resp_valid latency", 32'(lat), 32'd2);
        end_test("write then read hit");

        // five tags in four ways forces a dirty eviction
        start_test();
        for (int t = 0; t < 5; t++)
        begin
            addr = {4'(t + 1), 8'h21, 3'(t), 1'b0};
            data = 16'($random(stim_seed));
            cpu_access(1'b1, addr, data, got, lat);
            model_write(addr, data);
        end
        for (int t = 0; t < 5; t++)
        begin
            addr = {4'(t + 1), 8'h21, 3'(t), 1'b0};
            cpu_access(1'b0, addr, '0, got, lat);
            check_rdata(addr, got, model_read(addr));
        end
        end_test("five tags in one set");

        // clean fills first, then reads only in that set
        start_test();
        for (int t = 8; t < 12; t++)
        begin
            addr = {4'(t), 8'h7c, 3'd0, 1'b0};
            cpu_access(1'b0, addr, '0, got, lat);
            check_rdata(addr, got, model_read(addr));
        end
        we_before = we_cycles;
        for (int n = 0; n < 24; n++)
        begin
            r    = $random(stim_seed);
            addr = {4'(r[31:8] % 6), 8'h7c, r[2:0], 1'b0};
            cpu_access(1'b0, addr, '0, got, lat);
            check_rdata(addr, got, model_read(addr));
        end
        assert (we_cycles == we_before)
        else
            note_error("mem_we went high while only reads were issued");
        end_test("reads cause no memory write");

        start_test();
        for (int n = 0; n < NUM_RANDOM; n++)
        begin
            addr = random_addr();
            r    = $random(stim_seed);
            if (r[0])
            begin
                cpu_access(1'b1, addr, r[31:16], got, lat);
                model_write(addr, r[31:16]);
            end
            else
            begin
                cpu_access(1'b0, addr, '0, got, lat);
                check_rdata(addr, got, model_read(addr));
            end
        end
        end_test("random reads and writes");

        start_test();
        in_mem = 0;
        foreach (written_addrs[i])
        begin
            addr = written_addrs[i];
            if ({mem_bytes[addr | 16'h1], mem_bytes[addr]} == model_read(addr))
                in_mem++;
            cpu_access(1'b0, addr, '0, got, lat);
            check_rdata(addr, got, model_read(addr));
        end
        end_test($sformatf("reread of %0d written words (%0d already in memory)",
                           written_addrs.size(), in_mem));

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire
